// File: sources.f
+incdir+include
verilog/cart_pkg.sv
verilog/download_writer.sv
verilog/cart_info_scan.sv
verilog/cart_mapper.sv
verilog/mem_arbiter.sv
verilog/cart_loader_top.sv
verification/sdram_model.sv
verification/tb_cart_loader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the cartridge loader testbench with Verilator and runs it.
# The exit status of the simulation is the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f sources.f \
	--top-module tb_cart_loader \
	-o tb_cart_loader_sim \
	&& ./obj_dir/tb_cart_loader_sim \
	|| exit 1

exit 0

// File: verification/tb_cart_loader.sv
// Testbench for the cartridge loader core with a random stimulus and a memory reference model
`default_nettype none

`include "cart_defs.svh"

module tb_cart_loader;

	// Accesses of tests 1 to 6
	localparam int N_ACCESS = 32 + 6 + 16 + 13 + 16 + 24;
	localparam int TIMEOUT  = (N_ACCESS * 40 + 20) * 10;

	logic clk_sys = 1'b0;
	logic arst_n;
	logic dl_active, dl_cart, dl_wr, dl_wait;
	cart_pkg::dl_addr_t dl_addr;
	cart_pkg::word_t dl_data, cpu_wdata, cpu_rdata, mem_wdata, mem_rdata;
	logic wram_ce_n, cram_ce_n, crom_ce_n, bios_ce_n, page_ce_n, oe_n, wrl_n, wrh_n;
	cart_pkg::cpu_addr_t cpu_addr;
	logic cpu_rdy, region_valid, mem_req, mem_wrl, mem_wrh, mem_busy;
	cart_pkg::region_t region;
	cart_pkg::mem_addr_t mem_addr;
	logic [2:0] busy_len;

	// Reference model
	cart_pkg::word_t     model_mem [cart_pkg::mem_addr_t];
	cart_pkg::bank_t     model_bank [`CART_BANKS];
	cart_pkg::rom_mask_t model_mask;
	int unsigned         rng = 32'ha766_92d8;
	cart_pkg::dl_addr_t  t1_addrs [$];

	cart_loader_top dut_i (.*);

	sdram_model sdram_i (
		.clk_sys (clk_sys), .arst_n (arst_n), .mem_req (mem_req), .mem_addr (mem_addr),
		.mem_wdata (mem_wdata), .mem_wrl (mem_wrl), .mem_wrh (mem_wrh),
		.busy_len (busy_len), .mem_busy (mem_busy), .mem_rdata (mem_rdata)
	);

	always #5 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Helpers

	function automatic int unsigned next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic cart_pkg::word_t model_read(cart_pkg::mem_addr_t a);
		return model_mem.exists(a) ? model_mem[a] : '0;
	endfunction

	// Bank for CPU bits 21:19, then the rest, wrapped to the image size
	function automatic cart_pkg::mem_addr_t rom_target(cart_pkg::cpu_addr_t a);
		logic [22:0] va;
		va = {model_bank[a[20:18]], a[17:0]} & {model_mask, 12'hFFF};
		return {2'b00, va[21:0]};
	endfunction

	task automatic report_fail(string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_word(string name, cart_pkg::word_t exp, cart_pkg::word_t act);
		if (exp !== act) report_fail($sformatf("ERR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_region(string name, cart_pkg::region_t exp, cart_pkg::region_t act);
		if (exp !== act) report_fail($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_addr(string name, cart_pkg::mem_addr_t exp, cart_pkg::mem_addr_t act);
		if (exp !== act) report_fail($sformatf("ERR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic start_download(logic cart);
		dl_cart   = cart;
		dl_active = 1'b1;
		step();
		step();
		for (int i = 0; i < `CART_BANKS; i++) model_bank[i] = cart_pkg::bank_t'(i);
	endtask

	task automatic end_download();
		dl_active = 1'b0;
		step();
	endtask

	task automatic dl_write(cart_pkg::dl_addr_t a, cart_pkg::word_t d);
		while (dl_wait) step();
		busy_len = 3'(2 + next_rand() % 5);
		dl_addr  = a;
		dl_data  = d;
		dl_wr    = 1'b1;
		step();
		dl_wr = 1'b0;
		if (!dl_wait) report_fail("dl_wait did not rise the cycle after dl_wr");
		if (dl_cart) begin
			model_mem[{2'b00, a[22:1]}] = {d[7:0], d[15:8]};
			model_mask = (a == '0) ? '0 : (model_mask | a[23:13]);
		end else begin
			model_mem[{`CART_BIOSDL_BASE, a[18:1]}] = {d[7:0], d[15:8]};
		end
		while (dl_wait) step();
	endtask

	// Area 0 work RAM, 1 cart RAM, 2 cart ROM, 3 BIOS
	// Byte enables in be with bit 1 for the high byte, zero for a read
	task automatic cpu_cycle(string name, int sel, cart_pkg::cpu_addr_t a, logic [1:0] be,
		cart_pkg::word_t wd, cart_pkg::mem_addr_t exp_addr);
		cart_pkg::word_t merged;
		busy_len  = 3'(2 + next_rand() % 5);
		cpu_addr  = a;
		cpu_wdata = wd;
		wram_ce_n = (sel != 0);
		cram_ce_n = (sel != 1);
		crom_ce_n = (sel != 2);
		bios_ce_n = (sel != 3);
		oe_n      = |be;
		wrl_n     = !be[0];
		wrh_n     = !be[1];
		while (!mem_req) step();
		check_addr(name, exp_addr, mem_addr);
		while (!cpu_rdy) step();
		if (|be) begin
			merged = model_read(exp_addr);
			if (be[0]) merged[7:0] = wd[7:0];
			if (be[1]) merged[15:8] = wd[15:8];
			model_mem[exp_addr] = merged;
		end else begin
			check_word(name, model_read(exp_addr), cpu_rdata);
		end
		{wram_ce_n, cram_ce_n, crom_ce_n, bios_ce_n, oe_n, wrl_n, wrh_n} = '1;
		step();
		step();
	endtask

	task automatic rom_read(string name, cart_pkg::cpu_addr_t a);
		cpu_cycle(name, 2, a, 2'b00, '0, rom_target(a));
	endtask

	task automatic page_write(cart_pkg::cpu_addr_t a, cart_pkg::word_t d);
		cpu_addr  = a;
		cpu_wdata = d;
		page_ce_n = 1'b0;
		wrl_n     = 1'b0;
		step();
		step();
		{page_ce_n, wrl_n} = '1;
		step();
		if (model_mask[10:9] != 2'b00 && a[2:0] != 3'd0)
			model_bank[a[2:0]] = d[`CART_BANK_W-1:0];
	endtask

	//////////////////////////////////////////////////
	// Watchdog

	initial begin
		#(TIMEOUT);
		report_fail("Watchdog timeout, the DUT stopped answering");
	end

	//////////////////////////////////////////////////
	// Tests

	initial begin
		cart_pkg::dl_addr_t  a;
		cart_pkg::cpu_addr_t ca;
		cart_pkg::region_t   exp_reg [3];
		logic [7:0]          letters [3];
		int                  bank;
		int                  reg_n;
		cart_pkg::dl_addr_t  small_addrs [8];

		arst_n = 1'b0;
		{dl_active, dl_cart, dl_wr} = '0;
		dl_addr = '0;
		dl_data = '0;
		{wram_ce_n, cram_ce_n, crom_ce_n, bios_ce_n, page_ce_n, oe_n, wrl_n, wrh_n} = '1;
		cpu_addr  = '0;
		cpu_wdata = '0;
		busy_len  = 3'd2;
		model_mask = '0;
		for (int i = 0; i < `CART_BANKS; i++) model_bank[i] = cart_pkg::bank_t'(i);
		repeat (10) @(posedge clk_sys);
		#1 arst_n = 1'b1;
		step();

		// 1. Cartridge download, then byte-swapped readback
		start_download(1'b1);
		dl_write('0, cart_pkg::word_t'(next_rand()));
		t1_addrs.push_back('0);
		for (int i = 0; i < 15; i++) begin
			a = cart_pkg::dl_addr_t'((next_rand() % 32'h8000) << 1);
			dl_write(a, cart_pkg::word_t'(next_rand()));
			t1_addrs.push_back(a);
		end
		end_download();
		foreach (t1_addrs[i]) rom_read("cart_readback", cart_pkg::cpu_addr_t'(t1_addrs[i] >> 1));

		// 2. Region letter in the header
		letters = '{8'h4A, 8'h55, 8'h51};
		exp_reg = '{cart_pkg::JP, cart_pkg::US, cart_pkg::EU};
		for (int i = 0; i < 3; i++) begin
			start_download(1'b1);
			if (region_valid) report_fail("region_valid still high after a new download started");
			dl_write('0, cart_pkg::word_t'(next_rand()));
			dl_write(`CART_HDR_REGION_OFS, {8'(next_rand()), letters[i]});
			end_download();
			if (!region_valid) report_fail("region_valid low after the header was written");
			check_region("region", exp_reg[i], region);
		end

		// 3. Small image, reads above its size wrap
		start_download(1'b1);
		if (region_valid) report_fail("region_valid still high after a new download started");
		small_addrs[0] = '0;
		dl_write('0, cart_pkg::word_t'(next_rand()));
		for (int i = 1; i < 8; i++) begin
			small_addrs[i] = cart_pkg::dl_addr_t'((next_rand() % 32'h2000) << 1);
			dl_write(small_addrs[i], 16'(next_rand()));
		end
		end_download();
		// Written words again, with random bits above the image
		for (int i = 0; i < 8; i++) begin
			ca = cart_pkg::cpu_addr_t'(small_addrs[i] >> 1)
				| (cart_pkg::cpu_addr_t'(next_rand() % 256) << 13);
			rom_read("small_mask", ca);
		end

		// 4. Paging on an image above 4 MB
		start_download(1'b1);
		dl_write('0, cart_pkg::word_t'(next_rand()));
		dl_write(25'h7F_FFFE, cart_pkg::word_t'(next_rand()));
		bank  = 8 + int'(next_rand() % 6);
		reg_n = 1 + int'(next_rand() % 7);
		for (int i = 0; i < 4; i++)
			dl_write({1'b0, 5'(bank), 19'(i * 2)}, cart_pkg::word_t'(next_rand()));
		end_download();
		page_write(cart_pkg::cpu_addr_t'(reg_n), cart_pkg::word_t'(bank));
		for (int i = 0; i < 4; i++) rom_read("paged_read", {2'b00, 3'(reg_n), 18'(i)});
		start_download(1'b1);
		end_download();
		for (int i = 0; i < 2; i++) rom_read("identity_read", {2'b00, 3'(reg_n), 18'(i)});

		// 5. Work RAM and cart RAM write then read
		for (int i = 0; i < 4; i++) begin
			ca = cart_pkg::cpu_addr_t'(next_rand());
			cpu_cycle("wram_wr", 0, ca, 2'(1 + next_rand() % 3), 16'(next_rand()),
				{`CART_WRAM_BASE, ca[14:0]});
			cpu_cycle("wram_rd", 0, ca, 2'b00, '0, {`CART_WRAM_BASE, ca[14:0]});
			ca = cart_pkg::cpu_addr_t'(next_rand());
			cpu_cycle("cram_wr", 1, ca, 2'(1 + next_rand() % 3), 16'(next_rand()),
				{`CART_CRAM_BASE, ca[18:0]});
			cpu_cycle("cram_rd", 1, ca, 2'b00, '0, {`CART_CRAM_BASE, ca[18:0]});
		end

		// 6. BIOS download leaves the cart ROM alone
		start_download(1'b0);
		for (int i = 0; i < 8; i++) begin
			a = cart_pkg::dl_addr_t'((next_rand() % 32'h1_0000) << 1);
			dl_write(a, cart_pkg::word_t'(next_rand()));
			t1_addrs.push_back(a);
		end
		end_download();
		for (int i = 16; i < 24; i++) begin
			ca = cart_pkg::cpu_addr_t'(t1_addrs[i] >> 1);
			cpu_cycle("bios_read", 3, ca, 2'b00, '0, {`CART_BIOS_BASE, ca[15:0]});
		end
		// Same offsets in the cart ROM
		for (int i = 16; i < 24; i++) begin
			rom_read("rom_after_bios", cart_pkg::cpu_addr_t'(t1_addrs[i] >> 1));
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/sdram_model.sv
// Sparse word memory with a busy time per access chosen by the testbench
`default_nettype none

`include "cart_defs.svh"

module sdram_model (
	input  wire                      clk_sys,
	input  wire                      arst_n,
	input  wire                      mem_req,
	input  wire cart_pkg::mem_addr_t mem_addr,
	input  wire cart_pkg::word_t     mem_wdata,
	input  wire                      mem_wrl,
	input  wire                      mem_wrh,
	input  wire [2:0]                busy_len,  // Cycles of busy for the next access
	output logic                     mem_busy,
	output cart_pkg::word_t          mem_rdata
);

	cart_pkg::word_t     mem [cart_pkg::mem_addr_t];
	cart_pkg::mem_addr_t cur_addr;
	logic [2:0]          count;

	always @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			mem_busy  <= 1'b0;
			mem_rdata <= '0;
			count     <= '0;
			cur_addr  <= '0;
		end else if (mem_req) begin
			if (!mem.exists(mem_addr)) begin
				mem[mem_addr] = '0;
			end
			if (mem_wrl) mem[mem_addr][7:0] = mem_wdata[7:0];
			if (mem_wrh) mem[mem_addr][15:8] = mem_wdata[15:8];
			cur_addr <= mem_addr;
			mem_busy <= 1'b1;
			count    <= busy_len;
		end else if (mem_busy) begin
			if (count <= 3'd1) begin
				mem_busy  <= 1'b0;  // Read data valid as busy falls
				mem_rdata <= mem.exists(cur_addr) ? mem[cur_addr] : '0;
			end else begin
				count <= count - 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/cart_loader_top.sv
// Cartridge loader core joining download writer, header scanner, mapper and arbiter
`default_nettype none

module cart_loader_top (
	input  wire                  clk_sys,
	input  wire                  arst_n,
	// Loader stream
	input  wire                  dl_active,
	input  wire                  dl_cart,
	input  wire                  dl_wr,
	input  wire cart_pkg::dl_addr_t dl_addr,
	input  wire cart_pkg::word_t dl_data,
	output logic                 dl_wait,
	// CPU side
	input  wire                  wram_ce_n,
	input  wire                  cram_ce_n,
	input  wire                  crom_ce_n,
	input  wire                  bios_ce_n,
	input  wire                  page_ce_n,
	input  wire                  oe_n,
	input  wire                  wrl_n,
	input  wire                  wrh_n,
	input  wire cart_pkg::cpu_addr_t cpu_addr,
	input  wire cart_pkg::word_t cpu_wdata,
	output logic                 cpu_rdy,
	output cart_pkg::word_t      cpu_rdata,
	// Header info
	output cart_pkg::region_t    region,
	output logic                 region_valid,
	// External memory
	output logic                 mem_req,
	output cart_pkg::mem_addr_t  mem_addr,
	output cart_pkg::word_t      mem_wdata,
	output logic                 mem_wrl,
	output logic                 mem_wrh,
	input  wire                  mem_busy,
	input  wire cart_pkg::word_t mem_rdata
);

	logic                ld_req;
	cart_pkg::mem_addr_t ld_addr;
	cart_pkg::word_t     ld_data;
	logic                ld_done;
	cart_pkg::rom_mask_t rom_mask;
	cart_pkg::mem_addr_t cpu_mem_addr;
	logic                cpu_access;
	logic                cpu_we;

	download_writer writer_i (
		.clk_sys (clk_sys), .arst_n (arst_n),
		.dl_cart (dl_cart), .dl_wr (dl_wr), .dl_addr (dl_addr), .dl_data (dl_data),
		.dl_wait (dl_wait),
		.ld_req (ld_req), .ld_addr (ld_addr), .ld_data (ld_data), .ld_done (ld_done)
	);

	cart_info_scan scan_i (
		.clk_sys (clk_sys), .arst_n (arst_n),
		.dl_active (dl_active), .dl_cart (dl_cart), .dl_wr (dl_wr),
		.dl_addr (dl_addr), .dl_data (dl_data),
		.region (region), .region_valid (region_valid), .rom_mask (rom_mask)
	);

	cart_mapper mapper_i (
		.clk_sys (clk_sys), .arst_n (arst_n), .dl_active (dl_active), .rom_mask (rom_mask),
		.wram_ce_n (wram_ce_n), .cram_ce_n (cram_ce_n), .crom_ce_n (crom_ce_n),
		.bios_ce_n (bios_ce_n), .page_ce_n (page_ce_n),
		.oe_n (oe_n), .wrl_n (wrl_n), .wrh_n (wrh_n),
		.cpu_addr (cpu_addr), .cpu_wdata (cpu_wdata),
		.cpu_mem_addr (cpu_mem_addr), .cpu_access (cpu_access), .cpu_we (cpu_we)
	);

	mem_arbiter arbiter_i (
		.clk_sys (clk_sys), .arst_n (arst_n),
		.ld_req (ld_req), .ld_addr (ld_addr), .ld_data (ld_data), .ld_done (ld_done),
		.cpu_access (cpu_access), .cpu_mem_addr (cpu_mem_addr), .cpu_we (cpu_we),
		.wrl_n (wrl_n), .wrh_n (wrh_n), .cpu_wdata (cpu_wdata),
		.cpu_rdy (cpu_rdy), .cpu_rdata (cpu_rdata),
		.mem_req (mem_req), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
		.mem_wrl (mem_wrl), .mem_wrh (mem_wrh),
		.mem_busy (mem_busy), .mem_rdata (mem_rdata)
	);

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
// Memory arbiter sharing the external port between loader and CPU with loader priority
`default_nettype none

module mem_arbiter (
	input  wire                      clk_sys,
	input  wire                      arst_n,
	// Loader
	input  wire                      ld_req,
	input  wire cart_pkg::mem_addr_t ld_addr,
	input  wire cart_pkg::word_t     ld_data,
	output logic                     ld_done,
	// CPU
	input  wire                      cpu_access,
	input  wire cart_pkg::mem_addr_t cpu_mem_addr,
	input  wire                      cpu_we,
	input  wire                      wrl_n,
	input  wire                      wrh_n,
	input  wire cart_pkg::word_t     cpu_wdata,
	output logic                     cpu_rdy,
	output cart_pkg::word_t          cpu_rdata,
	// External memory
	output logic                     mem_req,
	output cart_pkg::mem_addr_t      mem_addr,
	output cart_pkg::word_t          mem_wdata,
	output logic                     mem_wrl,
	output logic                     mem_wrh,
	input  wire                      mem_busy,
	input  wire cart_pkg::word_t     mem_rdata
);

	cart_pkg::arb_state_t state;
	logic                 busy_d;
	logic                 mem_done;   // Busy just fell
	logic                 grant_ld;
	logic                 grant_cpu;

	assign mem_done  = busy_d & ~mem_busy;
	assign grant_ld  = (state == cart_pkg::IDLE) & ~mem_busy & ld_req;
	// Finished CPU access is not repeated while the strobe stays up
	assign grant_cpu = (state == cart_pkg::IDLE) & ~mem_busy & ~ld_req & cpu_access & ~cpu_rdy;
	assign ld_done   = (state == cart_pkg::LOADER) & mem_done;

	//////////////////////////////////////////////////
	// FSM

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state   <= cart_pkg::IDLE;
			busy_d  <= 1'b0;
			mem_req <= 1'b0;
			cpu_rdy <= 1'b0;
		end else begin
			busy_d  <= mem_busy;
			mem_req <= grant_ld | grant_cpu;  // One-cycle strobe
			case (state)
				cart_pkg::IDLE: begin
					if (grant_ld) begin
						state <= cart_pkg::LOADER;
					end else if (grant_cpu) begin
						state <= cart_pkg::CPU;
					end
				end
				cart_pkg::LOADER: begin
					if (mem_done) begin
						state <= cart_pkg::IDLE;
					end
				end
				cart_pkg::CPU: begin
					if (mem_done) begin
						state   <= cart_pkg::IDLE;
						cpu_rdy <= 1'b1;
					end
				end
				default: state <= cart_pkg::IDLE;
			endcase
			if (!cpu_access) begin
				cpu_rdy <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Request payload and read latch

	always_ff @(posedge clk_sys) begin
		if (grant_ld) begin
			mem_addr  <= ld_addr;
			mem_wdata <= ld_data;
			mem_wrl   <= 1'b1;  // Loader writes whole words
			mem_wrh   <= 1'b1;
		end else if (grant_cpu) begin
			mem_addr  <= cpu_mem_addr;
			mem_wdata <= cpu_wdata;
			mem_wrl   <= cpu_we & ~wrl_n;
			mem_wrh   <= cpu_we & ~wrh_n;
		end
		if ((state == cart_pkg::CPU) && mem_done) begin
			cpu_rdata <= mem_rdata;
		end
	end

	// Memory accepts no new command until busy has fallen
	a_req_not_busy : assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		mem_req |-> !mem_busy
	) else $error("mem_req while mem_busy high");

endmodule

`default_nettype wire

// File: verilog/cart_mapper.sv
// Cartridge mapper with large-ROM bank registers and CPU select to memory address translation
`default_nettype none

`include "cart_defs.svh"

module cart_mapper (
	input  wire                      clk_sys,
	input  wire                      arst_n,
	input  wire                      dl_active,
	input  wire cart_pkg::rom_mask_t rom_mask,
	input  wire                      wram_ce_n,
	input  wire                      cram_ce_n,
	input  wire                      crom_ce_n,
	input  wire                      bios_ce_n,
	input  wire                      page_ce_n,
	input  wire                      oe_n,
	input  wire                      wrl_n,
	input  wire                      wrh_n,
	input  wire cart_pkg::cpu_addr_t cpu_addr,   // CPU bits 23:1
	input  wire cart_pkg::word_t     cpu_wdata,
	output cart_pkg::mem_addr_t      cpu_mem_addr,
	output logic                     cpu_access,
	output logic                     cpu_we
);

	cart_pkg::bank_t     bank_reg [`CART_BANKS];
	logic                page_ce_d;
	logic                page_wr;
	logic                big_rom;
	logic [3:0]          mem_sel;   // wram, cram, crom, bios
	logic                wr_strobe;
	cart_pkg::cpu_addr_t rom_va;

	assign mem_sel   = {~wram_ce_n, ~cram_ce_n, ~crom_ce_n, ~bios_ce_n};
	assign wr_strobe = ~wrl_n | ~wrh_n;
	assign big_rom   = |rom_mask[`CART_MASK_BIG_HI:`CART_MASK_BIG_LO];  // Above 4 MB
	assign page_wr   = page_ce_d & ~page_ce_n & wr_strobe & big_rom & (cpu_addr[2:0] != 3'd0);

	//////////////////////////////////////////////////
	// Bank registers

	// Register 0 is fixed, the page port writes 1 to 7
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			page_ce_d <= 1'b1;
			for (int i = 0; i < `CART_BANKS; i++) begin
				bank_reg[i] <= cart_pkg::bank_t'(i);
			end
		end else begin
			page_ce_d <= page_ce_n;
			if (dl_active) begin
				for (int i = 0; i < `CART_BANKS; i++) begin
					bank_reg[i] <= cart_pkg::bank_t'(i);  // Identity map
				end
			end else if (page_wr) begin
				bank_reg[cpu_addr[2:0]] <= cpu_wdata[`CART_BANK_W-1:0];
			end
		end
	end

	//////////////////////////////////////////////////
	// Address translation

	// Page chosen by CPU bits 21:19, wrapped to the image size
	assign rom_va = {bank_reg[cpu_addr[20:18]], cpu_addr[17:0]}
		& {rom_mask, {(`CART_CPU_AW - `CART_MASK_W){1'b1}}};

	always_comb begin
		if (!wram_ce_n) begin
			cpu_mem_addr = {`CART_WRAM_BASE, cpu_addr[14:0]};  // 64 KB
		end else if (!cram_ce_n) begin
			cpu_mem_addr = {`CART_CRAM_BASE, cpu_addr[18:0]};
		end else if (!crom_ce_n) begin
			cpu_mem_addr = {`CART_ROM_BASE, rom_va[21:0]};
		end else begin
			cpu_mem_addr = {`CART_BIOS_BASE, cpu_addr[15:0]};  // 128 KB
		end
	end

	assign cpu_access = $onehot(mem_sel) & (~oe_n | wr_strobe);
	assign cpu_we     = (~wram_ce_n | ~cram_ce_n) & wr_strobe;  // ROM areas stay read-only

	// Address decode outside must keep the areas apart
	a_one_select : assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		$onehot0(mem_sel)
	) else $error("more than one memory select low");

endmodule

`default_nettype wire

// File: verilog/cart_info_scan.sv
// Header scanner reporting the cartridge region letter and the ROM size mask
`default_nettype none

`include "cart_defs.svh"

module cart_info_scan (
	input  wire                     clk_sys,
	input  wire                     arst_n,
	input  wire                     dl_active,
	input  wire                     dl_cart,
	input  wire                     dl_wr,
	input  wire cart_pkg::dl_addr_t dl_addr,
	input  wire cart_pkg::word_t    dl_data,
	output cart_pkg::region_t       region,
	output logic                    region_valid,
	output cart_pkg::rom_mask_t     rom_mask
);

	logic dl_active_d;
	logic dl_start;   // First cycle of a download
	logic hdr_wr;     // Write carrying the region letter
	logic cart_wr;

	assign dl_start = dl_active & ~dl_active_d;
	assign hdr_wr   = dl_active & dl_wr & (dl_addr == `CART_HDR_REGION_OFS);
	assign cart_wr  = dl_active & dl_cart & dl_wr;

	//////////////////////////////////////////////////
	// Region letter

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_active_d  <= 1'b0;
			region_valid <= 1'b0;
			region       <= cart_pkg::JP;
		end else begin
			dl_active_d <= dl_active;
			if (dl_start) begin
				region_valid <= 1'b0;
			end
			if (hdr_wr) begin
				region_valid <= 1'b1;
				case (dl_data[7:0])  // Letter sits in the low byte
					`CART_REGION_CHAR_J: region <= cart_pkg::JP;
					`CART_REGION_CHAR_U: region <= cart_pkg::US;
					default:             region <= cart_pkg::EU;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Size mask from highest address seen

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_mask <= '0;
		end else if (cart_wr) begin
			if (dl_addr == '0) begin
				rom_mask <= '0;  // New image starts over
			end else begin
				rom_mask <= rom_mask | dl_addr[23:13];
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/download_writer.sv
// Download writer turning loader words into byte-swapped memory writes with wait handshake
`default_nettype none

`include "cart_defs.svh"

module download_writer (
	input  wire                     clk_sys,
	input  wire                     arst_n,
	input  wire                     dl_cart,   // 1 cart ROM, 0 BIOS
	input  wire                     dl_wr,
	input  wire cart_pkg::dl_addr_t dl_addr,
	input  wire cart_pkg::word_t    dl_data,
	output logic                    dl_wait,
	output logic                    ld_req,
	output cart_pkg::mem_addr_t     ld_addr,
	output cart_pkg::word_t         ld_data,
	input  wire                     ld_done
);

	logic                pending;  // Write posted and not yet finished
	cart_pkg::mem_addr_t wr_addr;

	//////////////////////////////////////////////////
	// Target area

	always_comb begin
		if (dl_cart) begin
			wr_addr = {`CART_ROM_BASE, dl_addr[22:1]};      // Up to 8 MB image
		end else begin
			wr_addr = {`CART_BIOSDL_BASE, dl_addr[18:1]};
		end
	end

	//////////////////////////////////////////////////
	// Handshake

	// Loader only strobes while dl_wait is low, so set and clear never meet
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
		end else if (dl_wr) begin
			pending <= 1'b1;
		end else if (ld_done) begin
			pending <= 1'b0;
		end
	end

	assign dl_wait = pending;
	assign ld_req  = pending;  // Held until the arbiter finishes

	// Word payload, stable while the request is up
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			ld_addr <= wr_addr;
			ld_data <= {dl_data[7:0], dl_data[15:8]};  // Loader word is byte-reversed
		end
	end

	// A second write inside an open one would be lost
	a_no_wr_in_wait : assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		dl_wr |-> !dl_wait
	) else $error("dl_wr while dl_wait high");

endmodule

`default_nettype wire

// File: verilog/cart_pkg.sv
// Shared vector types and state encodings for the cartridge loading core
`default_nettype none

`include "cart_defs.svh"

package cart_pkg;

	//////////////////////////////////////////////////
	// Vectors with a meaning
	typedef logic [`CART_WORD_W-1:0] word_t;       // Data word
	typedef logic [`CART_MEM_AW-1:0] mem_addr_t;   // External word address
	typedef logic [`CART_CPU_AW-1:0] cpu_addr_t;   // CPU bits 23:1
	typedef logic [`CART_DL_AW-1:0]  dl_addr_t;    // Loader byte address
	typedef logic [`CART_MASK_W-1:0] rom_mask_t;   // ROM size, bits 23:13
	typedef logic [`CART_BANK_W-1:0] bank_t;       // 512 KB page number

	//////////////////////////////////////////////////
	// State machines and reported values

	// Header region letter
	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	// Owner of the memory port
	typedef enum logic [1:0] {
		IDLE,
		LOADER,
		CPU
	} arb_state_t;

endpackage

`default_nettype wire

// File: include/cart_defs.svh
// Cartridge loader constants for bus widths, memory area prefixes and header offsets
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

//////////////////////////////////////////////////
// Bus widths
`define CART_WORD_W   16  // Memory and CPU data word
`define CART_MEM_AW   24  // External memory word address
`define CART_CPU_AW   23  // CPU address bits 23:1
`define CART_DL_AW    25  // Loader byte address
`define CART_MASK_W   11  // Byte address bits 23:13
`define CART_BANK_W   5
`define CART_BANKS    8

//////////////////////////////////////////////////
// Upper prefixes of each area in external memory
`define CART_ROM_BASE     2'b00   // Cart ROM from byte 000000
`define CART_WRAM_BASE    9'h080  // Work RAM at byte 800000
`define CART_CRAM_BASE    5'h0E   // Cart RAM at byte E00000
`define CART_BIOS_BASE    8'h78   // BIOS at byte F00000
`define CART_BIOSDL_BASE  6'h1E   // BIOS area as seen by the loader

// Cartridge header
`define CART_HDR_REGION_OFS  25'h1F0
`define CART_REGION_CHAR_J   8'h4A  // ASCII J
`define CART_REGION_CHAR_U   8'h55  // ASCII U

// Mask bits for images above 4 MB enable paging
`define CART_MASK_BIG_HI  10
`define CART_MASK_BIG_LO  9

`endif
